/* design/lsu_pkg.sv */
// Load/store unit shared definitions
// Widths, queue depths, opcode and sequencer state enums, age compare

package lsu_pkg;

  // ----------------------------------------
  // Widths and depths
  // ----------------------------------------
  localparam int ADDR_W      = 8;
  localparam int DATA_W      = 16;
  localparam int AGE_W       = 4;

  localparam int IQ_DEPTH    = 4;
  localparam int RQ_DEPTH    = 4;

  // Pointer and index widths derived from the depths
  localparam int IQ_AW       = $clog2(IQ_DEPTH);
  localparam int RQ_IW       = $clog2(RQ_DEPTH);

  // Replay backoff
  localparam int BACKOFF_CYC = 3;
  localparam int BO_W        = $clog2(BACKOFF_CYC + 1);

  // ----------------------------------------
  // Enums
  // ----------------------------------------
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } lsu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_REQ  = 2'd1,
    ST_DROP = 2'd2,
    ST_DONE = 2'd3
  } mem_state_e;

  // ----------------------------------------
  // Age compare
  // ----------------------------------------
  // True when age a was issued before age b. Ages wrap, and no more
  // than half the tag space is ever in flight
  function automatic logic age_older(input logic [AGE_W-1:0] a,
                                     input logic [AGE_W-1:0] b);
    logic [AGE_W-1:0] diff;
    diff = a - b;
    return (diff >= AGE_W'(1 << (AGE_W - 1)));
  endfunction

endpackage

/* design/lsu_issue_queue.sv */
// LSU issue queue
// In-order FIFO fed by the four-phase dispatch handshake

`timescale 1ns/1ns

module lsu_issue_queue
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,

  // Dispatch side
  input  logic              i_disp_req,
  input  lsu_op_e           i_disp_op,
  input  logic [AGE_W-1:0]  i_disp_age,
  input  logic [ADDR_W-1:0] i_disp_addr,
  input  logic [DATA_W-1:0] i_disp_wdata,
  output logic              o_disp_ack,

  // Oldest entry
  output logic              o_head_valid,
  output lsu_op_e           o_head_op,
  output logic [AGE_W-1:0]  o_head_age,
  output logic [ADDR_W-1:0] o_head_addr,
  output logic [DATA_W-1:0] o_head_wdata,
  input  logic              i_pop
);

  // Entry storage
  lsu_op_e           op_q    [IQ_DEPTH];
  logic [AGE_W-1:0]  age_q   [IQ_DEPTH];
  logic [ADDR_W-1:0] addr_q  [IQ_DEPTH];
  logic [DATA_W-1:0] wdata_q [IQ_DEPTH];

  logic [IQ_AW-1:0]  wr_ptr;
  logic [IQ_AW-1:0]  rd_ptr;
  logic [IQ_AW:0]    count;

  logic              full;
  logic              push;

  assign full = (count == (IQ_AW + 1)'(IQ_DEPTH));

  // Fresh request only: req high while our ack is still low
  assign push = i_disp_req & ~o_disp_ack & ~full;

  // ----------------------------------------
  // Dispatch ack
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_disp_ack <= 1'b0;
    end else if (push) begin
      o_disp_ack <= 1'b1;
    end else if (!i_disp_req) begin
      o_disp_ack <= 1'b0;
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == IQ_AW'(IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == IQ_AW'(IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload write
  always_ff @(posedge i_clk) begin
    if (push) begin
      op_q[wr_ptr]    <= i_disp_op;
      age_q[wr_ptr]   <= i_disp_age;
      addr_q[wr_ptr]  <= i_disp_addr;
      wdata_q[wr_ptr] <= i_disp_wdata;
    end
  end

  // Head presentation
  assign o_head_valid = (count != '0);
  assign o_head_op    = op_q[rd_ptr];
  assign o_head_age   = age_q[rd_ptr];
  assign o_head_addr  = addr_q[rd_ptr];
  assign o_head_wdata = wdata_q[rd_ptr];

endmodule

/* design/lsu_replay_queue.sv */
// LSU replay queue
// Holds retried operations and offers the oldest one once backoff ends

`timescale 1ns/1ns

module lsu_replay_queue
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,

  // Retried operation from the memory sequencer
  input  logic              i_push,
  input  lsu_op_e           i_push_op,
  input  logic [AGE_W-1:0]  i_push_age,
  input  logic [ADDR_W-1:0] i_push_addr,
  input  logic [DATA_W-1:0] i_push_wdata,

  input  logic              i_hold,
  input  logic              i_pop,

  output logic              o_head_valid,
  output lsu_op_e           o_head_op,
  output logic [AGE_W-1:0]  o_head_age,
  output logic [ADDR_W-1:0] o_head_addr,
  output logic [DATA_W-1:0] o_head_wdata,
  output logic              o_almost_full
);

  logic [RQ_DEPTH-1:0] valid_q;
  lsu_op_e             op_q    [RQ_DEPTH];
  logic [AGE_W-1:0]    age_q   [RQ_DEPTH];
  logic [ADDR_W-1:0]   addr_q  [RQ_DEPTH];
  logic [DATA_W-1:0]   wdata_q [RQ_DEPTH];

  logic [RQ_IW-1:0]    head_idx;
  logic                head_found;
  logic [RQ_IW-1:0]    free_idx;

  // ----------------------------------------
  // Oldest valid entry
  // ----------------------------------------
  always_comb begin
    head_found = 1'b0;
    head_idx   = '0;
    for (int i = 0; i < RQ_DEPTH; i++) begin
      if (valid_q[i] && (!head_found || age_older(age_q[i], age_q[head_idx]))) begin
        head_found = 1'b1;
        head_idx   = RQ_IW'(i);
      end
    end
  end

  // First free slot, scanned from the top so the lowest index wins
  always_comb begin
    free_idx = '0;
    for (int i = RQ_DEPTH - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = RQ_IW'(i);
      end
    end
  end

  // Valid bits
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= '0;
    end else begin
      if (i_pop) begin
        valid_q[head_idx] <= 1'b0;
      end
      if (i_push) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      op_q[free_idx]    <= i_push_op;
      age_q[free_idx]   <= i_push_age;
      addr_q[free_idx]  <= i_push_addr;
      wdata_q[free_idx] <= i_push_wdata;
    end
  end

  // Head hidden during backoff
  assign o_head_valid  = head_found & ~i_hold;
  assign o_head_op     = op_q[head_idx];
  assign o_head_age    = age_q[head_idx];
  assign o_head_addr   = addr_q[head_idx];
  assign o_head_wdata  = wdata_q[head_idx];

  // One free slot or fewer
  assign o_almost_full = ($countones(valid_q) >= RQ_DEPTH - 1);

endmodule

/* design/lsu_mem_fsm.sv */
// LSU memory sequencer
// Runs the four-phase memory handshake and routes each outcome

`timescale 1ns/1ns

module lsu_mem_fsm
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,

  // Selected candidate
  input  logic              i_sel_valid,
  input  lsu_op_e           i_sel_op,
  input  logic [AGE_W-1:0]  i_sel_age,
  input  logic [ADDR_W-1:0] i_sel_addr,
  input  logic [DATA_W-1:0] i_sel_wdata,
  output logic              o_idle,

  // Memory port
  output logic              o_mem_req,
  output logic              o_mem_we,
  output logic [ADDR_W-1:0] o_mem_addr,
  output logic [DATA_W-1:0] o_mem_wdata,
  input  logic              i_mem_ack,
  input  logic [DATA_W-1:0] i_mem_rdata,
  input  logic              i_mem_retry,

  // Outcome
  output logic              o_replay_push,
  output logic              o_retry_start,
  output logic              o_done_valid,
  output logic [AGE_W-1:0]  o_done_age,
  output logic [DATA_W-1:0] o_done_rdata
);

  mem_state_e        state;
  logic              retry_q;

  // Latched operation
  lsu_op_e           op_q;
  logic [AGE_W-1:0]  age_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;

  // ----------------------------------------
  // State register
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= ST_IDLE;
      retry_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (i_sel_valid) state <= ST_REQ;
        // Ack seen, drop req on the next cycle
        ST_REQ: begin
          if (i_mem_ack) begin
            state   <= ST_DROP;
            retry_q <= i_mem_retry;
          end
        end
        ST_DROP: if (!i_mem_ack) state <= ST_DONE;
        ST_DONE: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_sel_valid) begin
      op_q    <= i_sel_op;
      age_q   <= i_sel_age;
      addr_q  <= i_sel_addr;
      wdata_q <= i_sel_wdata;
    end
    if (state == ST_REQ && i_mem_ack) begin
      rdata_q <= i_mem_rdata;
    end
  end

  assign o_idle        = (state == ST_IDLE);

  assign o_mem_req     = (state == ST_REQ);
  assign o_mem_we      = (op_q == OP_STORE);
  assign o_mem_addr    = addr_q;
  assign o_mem_wdata   = wdata_q;

  // Retry goes back to the replay queue, anything else completes
  assign o_replay_push = (state == ST_DONE) & retry_q;
  assign o_retry_start = (state == ST_DONE) & retry_q;
  assign o_done_valid  = (state == ST_DONE) & ~retry_q;
  assign o_done_age    = age_q;
  assign o_done_rdata  = (op_q == OP_STORE) ? '0 : rdata_q;

endmodule

/* design/lsu_backoff_timer.sv */
// Replay backoff timer
// Blocks the replay queue for a fixed number of cycles after a retry

`timescale 1ns/1ns

module lsu_backoff_timer
  import lsu_pkg::*;
(
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_start,
  output logic o_busy
);

  logic [BO_W-1:0] cnt;

  // A new retry restarts the count
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt <= '0;
    end else if (i_start) begin
      cnt <= BO_W'(BACKOFF_CYC);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign o_busy = (cnt != '0);

endmodule

/* design/lsu_top.sv */
// Load/store unit top level
// Issue and replay queues, age-based pick, single memory port sequencer

`timescale 1ns/1ns

module lsu_top
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,

  // Dispatch
  input  logic              i_disp_req,
  input  lsu_op_e           i_disp_op,
  input  logic [AGE_W-1:0]  i_disp_age,
  input  logic [ADDR_W-1:0] i_disp_addr,
  input  logic [DATA_W-1:0] i_disp_wdata,
  output logic              o_disp_ack,

  // Memory
  output logic              o_mem_req,
  output logic              o_mem_we,
  output logic [ADDR_W-1:0] o_mem_addr,
  output logic [DATA_W-1:0] o_mem_wdata,
  input  logic              i_mem_ack,
  input  logic [DATA_W-1:0] i_mem_rdata,
  input  logic              i_mem_retry,

  // Completion
  output logic              o_done_valid,
  output logic [AGE_W-1:0]  o_done_age,
  output logic [DATA_W-1:0] o_done_rdata
);

  // Issue queue head
  logic              w_iq_valid;
  lsu_op_e           w_iq_op;
  logic [AGE_W-1:0]  w_iq_age;
  logic [ADDR_W-1:0] w_iq_addr;
  logic [DATA_W-1:0] w_iq_wdata;
  logic              w_iq_pop;

  // Replay queue head
  logic              w_rq_valid;
  lsu_op_e           w_rq_op;
  logic [AGE_W-1:0]  w_rq_age;
  logic [ADDR_W-1:0] w_rq_addr;
  logic [DATA_W-1:0] w_rq_wdata;
  logic              w_rq_pop;
  logic              w_rq_almost_full;

  // Selection
  logic              w_iq_eligible;
  logic              w_replay_selected;
  logic              w_sel_valid;
  lsu_op_e           w_sel_op;
  logic [AGE_W-1:0]  w_sel_age;
  logic [ADDR_W-1:0] w_sel_addr;
  logic [DATA_W-1:0] w_sel_wdata;

  logic              w_fsm_idle;
  logic              w_replay_push;
  logic              w_retry_start;
  logic              w_bo_busy;
  lsu_op_e           w_push_op;

  lsu_issue_queue u_issue_queue (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_disp_req   (i_disp_req),
    .i_disp_op    (i_disp_op),
    .i_disp_age   (i_disp_age),
    .i_disp_addr  (i_disp_addr),
    .i_disp_wdata (i_disp_wdata),
    .o_disp_ack   (o_disp_ack),
    .o_head_valid (w_iq_valid),
    .o_head_op    (w_iq_op),
    .o_head_age   (w_iq_age),
    .o_head_addr  (w_iq_addr),
    .o_head_wdata (w_iq_wdata),
    .i_pop        (w_iq_pop)
  );

  // Replay push reuses the operation latched in the sequencer
  assign w_push_op = o_mem_we ? OP_STORE : OP_LOAD;

  lsu_replay_queue u_replay_queue (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_push        (w_replay_push),
    .i_push_op     (w_push_op),
    .i_push_age    (o_done_age),
    .i_push_addr   (o_mem_addr),
    .i_push_wdata  (o_mem_wdata),
    .i_hold        (w_bo_busy),
    .i_pop         (w_rq_pop),
    .o_head_valid  (w_rq_valid),
    .o_head_op     (w_rq_op),
    .o_head_age    (w_rq_age),
    .o_head_addr   (w_rq_addr),
    .o_head_wdata  (w_rq_wdata),
    .o_almost_full (w_rq_almost_full)
  );

  lsu_backoff_timer u_backoff_timer (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_start (w_retry_start),
    .o_busy  (w_bo_busy)
  );

  // ----------------------------------------
  // Age-based pick
  // ----------------------------------------
  // Issue side stalls while replay is nearly full, replay may still go
  assign w_iq_eligible     = w_iq_valid & ~w_rq_almost_full;
  assign w_replay_selected = w_rq_valid &
                             (~w_iq_eligible | age_older(w_rq_age, w_iq_age));
  assign w_sel_valid       = w_rq_valid | w_iq_eligible;

  assign w_sel_op    = w_replay_selected ? w_rq_op    : w_iq_op;
  assign w_sel_age   = w_replay_selected ? w_rq_age   : w_iq_age;
  assign w_sel_addr  = w_replay_selected ? w_rq_addr  : w_iq_addr;
  assign w_sel_wdata = w_replay_selected ? w_rq_wdata : w_iq_wdata;

  // Pop in the same cycle the sequencer takes the candidate
  assign w_rq_pop = w_fsm_idle & w_sel_valid & w_replay_selected;
  assign w_iq_pop = w_fsm_idle & w_sel_valid & ~w_replay_selected;

  lsu_mem_fsm u_mem_fsm (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_sel_valid   (w_sel_valid),
    .i_sel_op      (w_sel_op),
    .i_sel_age     (w_sel_age),
    .i_sel_addr    (w_sel_addr),
    .i_sel_wdata   (w_sel_wdata),
    .o_idle        (w_fsm_idle),
    .o_mem_req     (o_mem_req),
    .o_mem_we      (o_mem_we),
    .o_mem_addr    (o_mem_addr),
    .o_mem_wdata   (o_mem_wdata),
    .i_mem_ack     (i_mem_ack),
    .i_mem_rdata   (i_mem_rdata),
    .i_mem_retry   (i_mem_retry),
    .o_replay_push (w_replay_push),
    .o_retry_start (w_retry_start),
    .o_done_valid  (o_done_valid),
    .o_done_age    (o_done_age),
    .o_done_rdata  (o_done_rdata)
  );

endmodule

/* test/tb_clock.sv */
// Testbench clock and reset
// 8 ns clock, reset held low for the first two cycles

`timescale 1ns/1ns

module tb_clock (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_NS = 4;

  initial begin
    o_clk = 1'b0;
    forever begin
      #HALF_NS o_clk = ~o_clk;
    end
  end

  // Two rising edges in reset, released on the next falling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

/* test/lsu_assert.sv */
// LSU protocol checker
// Handshake, reset and backoff rules, bound into the load/store unit top

`timescale 1ns/1ns

module lsu_assert
  import lsu_pkg::*;
(
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_disp_req,
  input logic              i_disp_ack,
  input logic              i_mem_req,
  input logic              i_mem_ack,
  input logic [ADDR_W-1:0] i_mem_addr,
  input logic              i_done_valid,
  input logic              i_bo_busy,
  input logic              i_iq_eligible,
  input mem_state_e        i_state
);

  int n_fail = 0;

  // ----------------------------------------
  // Reset
  // ----------------------------------------
  reset_quiet: assert property (@(posedge i_clk)
    !i_rst_n |-> !i_disp_ack && !i_mem_req && !i_done_valid && i_state == ST_IDLE)
    else begin
      $error("control output active or sequencer busy during reset");
      n_fail++;
    end

  // ----------------------------------------
  // Dispatch handshake
  // ----------------------------------------
  disp_ack_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_disp_ack) |-> $past(i_disp_req))
    else begin
      $error("dispatch ack rose without a request");
      n_fail++;
    end

  disp_ack_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $fell(i_disp_ack) |-> !$past(i_disp_req))
    else begin
      $error("dispatch ack dropped while the request was still high");
      n_fail++;
    end

  // ----------------------------------------
  // Memory handshake
  // ----------------------------------------
  mem_req_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_mem_req && !i_mem_ack |=> i_mem_req && $stable(i_mem_addr))
    else begin
      $error("memory request dropped or changed before its ack");
      n_fail++;
    end

  mem_req_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $fell(i_mem_req) |-> $past(i_mem_ack))
    else begin
      $error("memory request dropped without an ack");
      n_fail++;
    end

  mem_req_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_mem_req) |-> !$past(i_mem_ack))
    else begin
      $error("memory request raised before the previous ack went low");
      n_fail++;
    end

  // Replay candidate alone under backoff must not start a request
  backoff_block: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_mem_req) |-> !$past(i_bo_busy && !i_iq_eligible))
    else begin
      $error("memory request started while only a backed-off replay was pending");
      n_fail++;
    end

  done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_done_valid |=> !i_done_valid)
    else begin
      $error("done strobe held for more than one cycle");
      n_fail++;
    end

endmodule

bind lsu_top lsu_assert u_assert (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .i_disp_req    (i_disp_req),
  .i_disp_ack    (o_disp_ack),
  .i_mem_req     (o_mem_req),
  .i_mem_ack     (i_mem_ack),
  .i_mem_addr    (o_mem_addr),
  .i_done_valid  (o_done_valid),
  .i_bo_busy     (w_bo_busy),
  .i_iq_eligible (w_iq_eligible),
  .i_state       (u_mem_fsm.state)
);

/* test/lsu_tb.sv */
// LSU testbench
// Dispatch driver, memory model with scripted retries, completion scoreboard

`timescale 1ns/1ns

module lsu_tb
  import lsu_pkg::*;
();

  localparam int TMO        = 200;
  localparam int MAX_FLIGHT = 8;
  localparam int MEM_SIZE   = 1 << ADDR_W;
  localparam int N_AGES     = 1 << AGE_W;

  logic              clk;
  logic              rst_n;
  logic              disp_req;
  lsu_op_e           disp_op;
  logic [AGE_W-1:0]  disp_age;
  logic [ADDR_W-1:0] disp_addr;
  logic [DATA_W-1:0] disp_wdata;
  logic              disp_ack;
  logic              mem_req;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic              mem_ack;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_retry;
  logic              done_valid;
  logic [AGE_W-1:0]  done_age;
  logic [DATA_W-1:0] done_rdata;

  // Scoreboard
  logic [DATA_W-1:0] ref_mem   [MEM_SIZE];
  logic [DATA_W-1:0] exp_rdata [N_AGES];
  bit                pending   [N_AGES];
  int                in_flight;
  int                n_disp;
  int                n_done;
  int                n_checks;
  int                n_errors;
  int                n_timeouts;
  logic [AGE_W-1:0]  next_age;

  // Memory model state
  logic [DATA_W-1:0] mem        [MEM_SIZE];
  int                ack_delay  [MEM_SIZE];
  int                req_order  [MEM_SIZE];
  int                retry_cnt  [MEM_SIZE];
  bit                retry_once [MEM_SIZE];
  bit                mem_hold;
  bit                rand_retry;
  bit                req_seen;
  int                wait_cnt;
  int                req_num;
  int                n_retries;
  int                seed;

  tb_clock u_clock (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  lsu_top dut0 (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_disp_req   (disp_req),
    .i_disp_op    (disp_op),
    .i_disp_age   (disp_age),
    .i_disp_addr  (disp_addr),
    .i_disp_wdata (disp_wdata),
    .o_disp_ack   (disp_ack),
    .o_mem_req    (mem_req),
    .o_mem_we     (mem_we),
    .o_mem_addr   (mem_addr),
    .o_mem_wdata  (mem_wdata),
    .i_mem_ack    (mem_ack),
    .i_mem_rdata  (mem_rdata),
    .i_mem_retry  (mem_retry),
    .o_done_valid (done_valid),
    .o_done_age   (done_age),
    .o_done_rdata (done_rdata)
  );

  task automatic check(input bit cond, input string msg);
    n_checks++;
    assert (cond) else begin
      n_errors++;
      $display("FAIL @%0t: %s", $time, msg);
    end
  endtask

  task automatic finish_run();
    $display("checks=%0d errors=%0d assertion_failures=%0d timeouts=%0d dispatched=%0d done=%0d",
             n_checks, n_errors, dut0.u_assert.n_fail, n_timeouts, n_disp, n_done);
    if (n_errors == 0 && n_timeouts == 0 && dut0.u_assert.n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    n_timeouts++;
    $display("Timed out at %0t while waiting for %s", $time, what);
    finish_run();
  endtask

  // ----------------------------------------
  // Memory model
  // ----------------------------------------
  always @(negedge clk) begin
    bit retry;
    if (rst_n) begin
      if (mem_req && !req_seen) begin
        req_num++;
        req_order[mem_addr] = req_num;
      end
      req_seen = mem_req;
      if (mem_ack) begin
        if (!mem_req) begin
          mem_ack   = 1'b0;
          mem_retry = 1'b0;
        end
      end else if (mem_req && !mem_hold) begin
        if (wait_cnt < ack_delay[mem_addr]) begin
          wait_cnt++;
        end else begin
          wait_cnt = 0;
          retry    = retry_once[mem_addr];
          if (rand_retry && retry_cnt[mem_addr] < 2 && ($random(seed) & 3) == 0) begin
            retry = 1'b1;
          end
          if (retry) begin
            retry_once[mem_addr] = 1'b0;
            retry_cnt[mem_addr]++;
            n_retries++;
          end else if (mem_we) begin
            mem[mem_addr] = mem_wdata;
          end
          mem_rdata = retry ? '0 : mem[mem_addr];
          mem_retry = retry;
          mem_ack   = 1'b1;
        end
      end
    end
  end

  // Each completed age must be in flight exactly once
  always @(negedge clk) begin
    if (rst_n && done_valid) begin
      check(pending[done_age], $sformatf("done for age %0d not in flight", done_age));
      check(done_rdata == exp_rdata[done_age],
            $sformatf("age %0d returned %h, expected %h", done_age, done_rdata,
                      exp_rdata[done_age]));
      pending[done_age] = 1'b0;
      in_flight--;
      n_done++;
    end
  end

  // ----------------------------------------
  // Dispatch driver
  // ----------------------------------------
  task automatic raise_dispatch(input lsu_op_e op, input logic [AGE_W-1:0] age,
                                input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata);
    int t;
    t = 0;
    while (in_flight >= MAX_FLIGHT) begin
      @(negedge clk);
      t++;
      if (t > TMO) give_up("room for another operation in flight");
    end
    check(!pending[age], $sformatf("age %0d dispatched while still in flight", age));
    if (op == OP_STORE) begin
      ref_mem[addr]  = wdata;
      exp_rdata[age] = '0;
    end else begin
      exp_rdata[age] = ref_mem[addr];
    end
    pending[age] = 1'b1;
    in_flight++;
    n_disp++;
    disp_op    = op;
    disp_age   = age;
    disp_addr  = addr;
    disp_wdata = wdata;
    disp_req   = 1'b1;
  endtask

  task automatic complete_dispatch();
    int t;
    t = 0;
    while (!disp_ack) begin
      @(negedge clk);
      t++;
      if (t > TMO) give_up("the dispatch ack");
    end
    disp_req = 1'b0;
    t = 0;
    while (disp_ack) begin
      @(negedge clk);
      t++;
      if (t > TMO) give_up("the dispatch ack to drop");
    end
  endtask

  task automatic dispatch(input lsu_op_e op, input logic [AGE_W-1:0] age,
                          input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    raise_dispatch(op, age, addr, wdata);
    complete_dispatch();
  endtask

  task automatic wait_done(input logic [AGE_W-1:0] age);
    int t;
    t = 0;
    while (pending[age]) begin
      @(negedge clk);
      t++;
      if (t > TMO) give_up($sformatf("completion of age %0d", age));
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (in_flight != 0) begin
      @(negedge clk);
      t++;
      if (t > TMO * 4) give_up("all operations to complete");
    end
  endtask

  task automatic wait_mem_addr(input logic [ADDR_W-1:0] addr);
    int t;
    t = 0;
    while (!(mem_req && mem_addr == addr)) begin
      @(negedge clk);
      t++;
      if (t > TMO) give_up($sformatf("a memory request to address %h", addr));
    end
  endtask

  // A is retried once, B holds the port past A's backoff, C waits in the issue queue
  task automatic order_case(input logic [AGE_W-1:0] age_a, input logic [AGE_W-1:0] age_b,
                            input logic [AGE_W-1:0] age_c, input logic [ADDR_W-1:0] base,
                            input bit replay_first);
    retry_once[base] = 1'b1;
    ack_delay[ADDR_W'(base + 1)] = 8;
    mem_hold = 1'b1;
    dispatch(OP_LOAD, age_a, base, '0);
    wait_mem_addr(base);
    dispatch(OP_LOAD, age_b, ADDR_W'(base + 1), '0);
    mem_hold = 1'b0;
    wait_mem_addr(ADDR_W'(base + 1));
    dispatch(OP_LOAD, age_c, ADDR_W'(base + 2), '0);
    wait_drain();
    check(req_order[base] > req_order[ADDR_W'(base + 1)],
          "retried operation was not replayed after the blocking request");
    if (replay_first) begin
      check(req_order[base] < req_order[ADDR_W'(base + 2)],
            "older replayed operation did not go before the issue head");
    end else begin
      check(req_order[ADDR_W'(base + 2)] < req_order[base],
            "younger replayed operation went before the older issue head");
    end
  endtask

  initial begin
    lsu_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    int                t;
    disp_req   = 1'b0;
    disp_op    = OP_LOAD;
    disp_age   = '0;
    disp_addr  = '0;
    disp_wdata = '0;
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    mem_retry  = 1'b0;
    seed       = 32'h235a;
    next_age   = '0;
    for (int a = 0; a < MEM_SIZE; a++) begin
      mem[a]     = {a[7:0] ^ 8'h3c, a[7:0]};
      ref_mem[a] = {a[7:0] ^ 8'h3c, a[7:0]};
    end
    t = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      t++;
      if (t > TMO) give_up("reset release");
    end
    @(negedge clk);

    // Store then a retried load of the same address
    for (int i = 0; i < 3; i++) begin
      addr  = ADDR_W'(8'h10 + i);
      wdata = DATA_W'($random(seed));
      dispatch(OP_STORE, next_age, addr, wdata);
      wait_done(next_age);
      next_age++;
      retry_once[addr] = 1'b1;
      dispatch(OP_LOAD, next_age, addr, '0);
      wait_done(next_age);
      next_age++;
    end

    // Replay older than the issue head, then younger
    order_case(4'd2, 4'd3, 4'd4, 8'ha0, 1'b1);
    order_case(4'd9, 4'd10, 4'd8, 8'hb0, 1'b0);

    // Issue queue back-pressure while memory stalls
    mem_hold = 1'b1;
    for (int i = 0; i < IQ_DEPTH + 1; i++) begin
      dispatch(OP_LOAD, next_age, ADDR_W'(8'h90 + i), '0);
      next_age++;
    end
    raise_dispatch(OP_LOAD, next_age, 8'h95, '0);
    next_age++;
    repeat (12) begin
      @(negedge clk);
      check(!disp_ack, "dispatch ack given while the issue queue is full");
    end
    mem_hold = 1'b0;
    complete_dispatch();
    wait_drain();

    // Mixed traffic with random retries and ack delays
    n_retries  = 0;
    rand_retry = 1'b1;
    for (int i = 0; i < 20; i++) begin
      if ($random(seed) & 1) begin
        op    = OP_STORE;
        addr  = ADDR_W'(8'h40 + i);
        wdata = DATA_W'($random(seed));
      end else begin
        op    = OP_LOAD;
        addr  = ADDR_W'(8'hc0 + i);
        wdata = '0;
      end
      ack_delay[addr] = $random(seed) & 3;
      dispatch(op, next_age, addr, wdata);
      next_age++;
    end
    wait_drain();
    rand_retry = 1'b0;

    check(n_retries > 0, "random memory retries were not exercised");
    check(n_done == n_disp, "completed count differs from dispatched count");
    for (int a = 0; a < N_AGES; a++) begin
      check(!pending[a], $sformatf("age %0d never completed", a));
    end
    finish_run();
  end

endmodule

/* lsu_top.f */
design/lsu_pkg.sv
design/lsu_issue_queue.sv
design/lsu_replay_queue.sv
design/lsu_mem_fsm.sv
design/lsu_backoff_timer.sv
design/lsu_top.sv
test/tb_clock.sv
test/lsu_assert.sv
test/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module lsu_tb -f lsu_top.f -o lsu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Assertion errors are counted by the testbench, so let the run continue past them
sim_out=$(./obj_dir/lsu_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
